// File: source/cpuPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, opcodes and control encodings for the 16-bit core.
// Every pipeline module refers to these by scoped name, so opcode
// values and field widths are defined here only.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cpuPkg;

    // Data path and register file sizes
    localparam int DataWidth = 16;
    localparam int RegAddrWidth = 3;
    localparam int NumRegs = 8;

    // Instruction bits 15:11
    typedef enum logic [4:0] {
        OpHalt  = 5'b00000,
        OpNop   = 5'b00001,
        OpAddi  = 5'b01000,
        OpSubi  = 5'b01001,
        OpXori  = 5'b01010,
        OpAndni = 5'b01011,
        OpSlbi  = 5'b10010,
        OpLbi   = 5'b11000,
        OpAlu   = 5'b11011
    } opcodeT;

    // Register form function field, instruction bits 1:0
    typedef enum logic [1:0] {
        FnAdd  = 2'b00,
        FnSub  = 2'b01,
        FnXor  = 2'b10,
        FnAndn = 2'b11
    } functT;

    // Operations the execute stage knows
    // Sub is B minus A, Andn is A and not B
    typedef enum logic [2:0] {
        AluAdd   = 3'd0,
        AluSub   = 3'd1,
        AluXor   = 3'd2,
        AluAndn  = 3'd3,
        AluPassB = 3'd4,
        AluSlbi  = 3'd5
    } aluOpT;

    // Which instruction field names the destination
    typedef enum logic [1:0] {
        DstRt = 2'b00,
        DstRs = 2'b01,
        DstRd = 2'b10
    } dstSelT;

endpackage

// File: source/instrFetch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction intake over a four-phase req/ack port. A captured word
// and its PC sit in the fetch register until decode takes them.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module instrFetch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instrReq,
    input  logic [cpuPkg::DataWidth-1:0]  instrWord,
    input  logic                          stallDec,
    input  logic                          haltSeen,
    output logic                          instrAck,
    output logic                          fetchValid,
    output logic [cpuPkg::DataWidth-1:0]  fetchInstr,
    output logic [cpuPkg::DataWidth-1:0]  fetchPc
);

    typedef enum logic [1:0] {Idle, Ack, WaitLow} hsStateT;

    hsStateT state;
    logic [cpuPkg::DataWidth-1:0] pc;
    logic capture;

    // Take a word only when decode can accept it and no halt is in sight
    assign capture = (state != Ack) && instrReq && !stallDec && !haltSeen;
    assign instrAck = (state == Ack);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            fetchValid <= 1'b0;
            pc <= '0;
        end else begin
            // Next word may follow as soon as ack is low
            case (state)
                Ack:     if (!instrReq) state <= WaitLow;
                default: state <= capture ? Ack : Idle;
            endcase

            if (capture) begin
                fetchValid <= 1'b1;
                pc <= pc + cpuPkg::DataWidth'(2);
            end else if (!stallDec) begin
                // Decode consumed the word
                fetchValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            fetchInstr <= instrWord;
            fetchPc <= pc;
        end
    end

    // Ack only answers a live request
    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(instrAck) |-> $past(instrReq));

endmodule

// File: source/instrDecoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcode decoder. Turns an instruction word into the control signals
// and ALU operation that the decode stage registers for execute.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module instrDecoder (
    input  logic [cpuPkg::DataWidth-1:0]  instr,
    output cpuPkg::aluOpT                 aluOp,
    output cpuPkg::dstSelT                dstSel,
    output logic                          regWrt,
    output logic                          zeroExt,
    output logic                          useImm5,
    output logic                          useImm8,
    output logic                          readsRt,
    output logic                          isHalt
);

    cpuPkg::opcodeT opcode;
    cpuPkg::functT funct;

    assign opcode = cpuPkg::opcodeT'(instr[15:11]);
    assign funct = cpuPkg::functT'(instr[1:0]);

    always_comb begin
        // Nop behaviour unless an opcode says otherwise
        aluOp = cpuPkg::AluAdd;
        dstSel = cpuPkg::DstRt;
        regWrt = 1'b0;
        zeroExt = 1'b0;
        useImm5 = 1'b0;
        useImm8 = 1'b0;
        readsRt = 1'b0;
        isHalt = 1'b0;

        case (opcode)
            cpuPkg::OpHalt: begin
                // Travels to execute as a non-writing pass
                aluOp = cpuPkg::AluPassB;
                isHalt = 1'b1;
            end
            cpuPkg::OpAddi: begin
                regWrt = 1'b1;
                useImm5 = 1'b1;
            end
            cpuPkg::OpSubi: begin
                aluOp = cpuPkg::AluSub;
                regWrt = 1'b1;
                useImm5 = 1'b1;
            end
            cpuPkg::OpXori: begin
                aluOp = cpuPkg::AluXor;
                regWrt = 1'b1;
                useImm5 = 1'b1;
                zeroExt = 1'b1;
            end
            cpuPkg::OpAndni: begin
                aluOp = cpuPkg::AluAndn;
                regWrt = 1'b1;
                useImm5 = 1'b1;
                zeroExt = 1'b1;
            end
            cpuPkg::OpLbi: begin
                aluOp = cpuPkg::AluPassB;
                dstSel = cpuPkg::DstRs;
                regWrt = 1'b1;
                useImm8 = 1'b1;
            end
            cpuPkg::OpSlbi: begin
                aluOp = cpuPkg::AluSlbi;
                dstSel = cpuPkg::DstRs;
                regWrt = 1'b1;
                useImm8 = 1'b1;
                zeroExt = 1'b1;
            end
            cpuPkg::OpAlu: begin
                dstSel = cpuPkg::DstRd;
                regWrt = 1'b1;
                readsRt = 1'b1;
                case (funct)
                    cpuPkg::FnSub:  aluOp = cpuPkg::AluSub;
                    cpuPkg::FnXor:  aluOp = cpuPkg::AluXor;
                    cpuPkg::FnAndn: aluOp = cpuPkg::AluAndn;
                    default:        aluOp = cpuPkg::AluAdd;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: source/regFileBypass.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Eight-entry register file, two combinational read ports and one
// write port. A read of the register being written returns wrData.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module regFileBypass (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [cpuPkg::RegAddrWidth-1:0]  rdSel1,
    input  logic [cpuPkg::RegAddrWidth-1:0]  rdSel2,
    input  logic [cpuPkg::RegAddrWidth-1:0]  wrSel,
    input  logic [cpuPkg::DataWidth-1:0]     wrData,
    input  logic                             wrEn,
    output logic [cpuPkg::DataWidth-1:0]     rdData1,
    output logic [cpuPkg::DataWidth-1:0]     rdData2
);

    logic [cpuPkg::DataWidth-1:0] regs [cpuPkg::NumRegs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrSel] <= wrData;
        end
    end

    // Write-to-read bypass
    assign rdData1 = (wrEn && wrSel == rdSel1) ? wrData : regs[rdSel1];
    assign rdData2 = (wrEn && wrSel == rdSel2) ? wrData : regs[rdSel2];

endmodule

// File: source/decodeStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage. Reads operands, builds immediates, checks the source
// fields against writes still in flight and fills the decode/execute
// register, or a bubble while it stalls.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module decodeStage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             fetchValid,
    input  logic [cpuPkg::DataWidth-1:0]     fetchInstr,
    input  logic                             wbEn,
    input  logic [cpuPkg::RegAddrWidth-1:0]  wbReg,
    input  logic [cpuPkg::DataWidth-1:0]     wbData,
    output logic                             stallDec,
    output logic                             haltSeen,
    output logic                             exValid,
    output cpuPkg::aluOpT                    exAluOp,
    output logic [cpuPkg::DataWidth-1:0]     exOpA,
    output logic [cpuPkg::DataWidth-1:0]     exOpB,
    output logic                             exRegWrt,
    output logic [cpuPkg::RegAddrWidth-1:0]  exDst
);

    cpuPkg::aluOpT decAluOp;
    cpuPkg::dstSelT decDstSel;
    logic decRegWrt, decZeroExt, decUseImm5, decUseImm8, decReadsRt, decIsHalt;
    logic [cpuPkg::RegAddrWidth-1:0] rs, rt, dst;
    logic [cpuPkg::DataWidth-1:0] rsData, rtData, imm5, imm8, opB;
    logic rsHazard, rtHazard, haltLatched, issue;

    instrDecoder decoder_i (
        .instr(fetchInstr),
        .aluOp(decAluOp),
        .dstSel(decDstSel),
        .regWrt(decRegWrt),
        .zeroExt(decZeroExt),
        .useImm5(decUseImm5),
        .useImm8(decUseImm8),
        .readsRt(decReadsRt),
        .isHalt(decIsHalt)
    );

    assign rs = fetchInstr[10:8];
    assign rt = fetchInstr[7:5];

    regFileBypass regFile_i (
        .clk(clk),
        .rst(rst),
        .rdSel1(rs),
        .rdSel2(rt),
        .wrSel(wbReg),
        .wrData(wbData),
        .wrEn(wbEn),
        .rdData1(rsData),
        .rdData2(rtData)
    );

    // Immediates
    assign imm5 = decZeroExt ? {11'h000, fetchInstr[4:0]} : {{11{fetchInstr[4]}}, fetchInstr[4:0]};
    assign imm8 = decZeroExt ? {8'h00, fetchInstr[7:0]} : {{8{fetchInstr[7]}}, fetchInstr[7:0]};
    assign opB = decUseImm5 ? imm5 : (decUseImm8 ? imm8 : rtData);

    always_comb begin
        case (decDstSel)
            cpuPkg::DstRt: dst = fetchInstr[7:5];
            cpuPkg::DstRs: dst = fetchInstr[10:8];
            cpuPkg::DstRd: dst = fetchInstr[4:2];
            default:       dst = 3'b111;
        endcase
    end

    // Rs is treated as read by every writing instruction, Rt only by the register form
    assign rsHazard = decRegWrt &&
                      ((exRegWrt && exDst == rs) || (wbEn && wbReg == rs));
    assign rtHazard = decReadsRt &&
                      ((exRegWrt && exDst == rt) || (wbEn && wbReg == rt));
    assign stallDec = fetchValid && (rsHazard || rtHazard);

    assign issue = fetchValid && !stallDec && !haltLatched;
    assign haltSeen = haltLatched || (fetchValid && decIsHalt);

    always_ff @(posedge clk) begin
        if (rst) begin
            exValid <= 1'b0;
            exRegWrt <= 1'b0;
            haltLatched <= 1'b0;
        end else begin
            exValid <= issue;
            exRegWrt <= issue && decRegWrt;
            if (issue && decIsHalt) haltLatched <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        exAluOp <= decAluOp;
        exOpA <= rsData;
        exOpB <= opB;
        exDst <= dst;
    end

    // A stalled word stays in the fetch register
    stallHoldsWord: assert property (@(posedge clk) disable iff (rst)
        stallDec |=> fetchValid && $stable(fetchInstr));

endmodule

// File: source/executeStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute and write-back. Runs the ALU, registers the result for the
// register file and shows every write on the retire ports.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module executeStage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             exValid,
    input  cpuPkg::aluOpT                    exAluOp,
    input  logic [cpuPkg::DataWidth-1:0]     exOpA,
    input  logic [cpuPkg::DataWidth-1:0]     exOpB,
    input  logic                             exRegWrt,
    input  logic [cpuPkg::RegAddrWidth-1:0]  exDst,
    output logic                             wbEn,
    output logic [cpuPkg::RegAddrWidth-1:0]  wbReg,
    output logic [cpuPkg::DataWidth-1:0]     wbData,
    output logic                             retireEn,
    output logic [cpuPkg::RegAddrWidth-1:0]  retireReg,
    output logic [cpuPkg::DataWidth-1:0]     retireData,
    output logic                             halted
);

    logic [cpuPkg::DataWidth-1:0] aluResult;
    logic isHalt;

    always_comb begin
        case (exAluOp)
            cpuPkg::AluAdd:  aluResult = exOpA + exOpB;
            cpuPkg::AluSub:  aluResult = exOpB - exOpA;
            cpuPkg::AluXor:  aluResult = exOpA ^ exOpB;
            cpuPkg::AluAndn: aluResult = exOpA & ~exOpB;
            // Old value moves to the upper byte
            cpuPkg::AluSlbi: aluResult = {exOpA[7:0], 8'h00} | exOpB;
            default:         aluResult = exOpB;
        endcase
    end

    // Halt arrives as a valid non-writing pass
    assign isHalt = exValid && !exRegWrt && (exAluOp == cpuPkg::AluPassB);

    always_ff @(posedge clk) begin
        if (rst) begin
            wbEn <= 1'b0;
            halted <= 1'b0;
        end else begin
            wbEn <= exValid && exRegWrt;
            if (isHalt) halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        wbReg <= exDst;
        wbData <= aluResult;
    end

    assign retireEn = wbEn;
    assign retireReg = wbReg;
    assign retireData = wbData;

    // Nothing issued after a halt may reach write-back
    noRetireAfterHalt: assert property (@(posedge clk) disable iff (rst)
        halted |-> !wbEn);

endmodule

// File: source/cpuCore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the three-stage core. Words enter over the req/ack
// port and every register write leaves on the retire ports.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module cpuCore (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             instrReq,
    input  logic [cpuPkg::DataWidth-1:0]     instrWord,
    output logic                             instrAck,
    output logic                             retireEn,
    output logic [cpuPkg::RegAddrWidth-1:0]  retireReg,
    output logic [cpuPkg::DataWidth-1:0]     retireData,
    output logic                             halted
);

    logic fetchValid, stallDec, haltSeen;
    logic [cpuPkg::DataWidth-1:0] fetchInstr;
    logic exValid, exRegWrt;
    cpuPkg::aluOpT exAluOp;
    logic [cpuPkg::DataWidth-1:0] exOpA, exOpB;
    logic [cpuPkg::RegAddrWidth-1:0] exDst;
    logic wbEn;
    logic [cpuPkg::RegAddrWidth-1:0] wbReg;
    logic [cpuPkg::DataWidth-1:0] wbData;

    // No branch logic reads the PC
    instrFetch fetch_i (
        .clk(clk), .rst(rst),
        .instrReq(instrReq), .instrWord(instrWord),
        .stallDec(stallDec), .haltSeen(haltSeen),
        .instrAck(instrAck), .fetchValid(fetchValid),
        .fetchInstr(fetchInstr), .fetchPc()
    );

    decodeStage decode_i (
        .clk(clk), .rst(rst),
        .fetchValid(fetchValid), .fetchInstr(fetchInstr),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
        .stallDec(stallDec), .haltSeen(haltSeen),
        .exValid(exValid), .exAluOp(exAluOp),
        .exOpA(exOpA), .exOpB(exOpB),
        .exRegWrt(exRegWrt), .exDst(exDst)
    );

    executeStage execute_i (
        .clk(clk), .rst(rst),
        .exValid(exValid), .exAluOp(exAluOp),
        .exOpA(exOpA), .exOpB(exOpB),
        .exRegWrt(exRegWrt), .exDst(exDst),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
        .retireEn(retireEn), .retireReg(retireReg),
        .retireData(retireData), .halted(halted)
    );

endmodule

// File: tb/clockGen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset. 20 ns clock, reset held high for the
// first ten rising edges and released just after the tenth.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic rst
);

    localparam int HalfPeriod = 10;
    localparam int ResetCycles = 10;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // Released off the edge so the stimulus sees a settled value
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: tb/cpuCoreTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the 16-bit core. Feeds words over the req/ack port,
// predicts every register write with a model register file and
// compares each retire against the oldest prediction.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module cpuCoreTb;

    localparam int AckTimeout = 50;
    localparam int DrainTimeout = 100;
    localparam int HaltTimeout = 50;
    localparam int QuietWindow = 40;
    localparam int RandomCount = 200;

    logic clk, rst;
    logic instrReq;
    logic [cpuPkg::DataWidth-1:0] instrWord;
    logic instrAck, retireEn, halted;
    logic [cpuPkg::RegAddrWidth-1:0] retireReg;
    logic [cpuPkg::DataWidth-1:0] retireData;

    // Model state and expected writes in issue order
    logic [15:0] modelRegs [8];
    logic [2:0] expRegQ [$];
    logic [15:0] expDataQ [$];

    clockGen clockGen_i (.clk(clk), .rst(rst));

    cpuCore cpuCore_i (
        .clk(clk), .rst(rst),
        .instrReq(instrReq), .instrWord(instrWord),
        .instrAck(instrAck), .retireEn(retireEn),
        .retireReg(retireReg), .retireData(retireData),
        .halted(halted)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic checkValue(input int got, input int exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("ERR %0t ns: %s got %0h expected %0h", $time, what, got, exp));
        end
    endtask

    function automatic logic [15:0] immForm(input logic [4:0] op, input logic [2:0] rs,
                                            input logic [2:0] rt, input logic [4:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] byteForm(input logic [4:0] op, input logic [2:0] rs,
                                             input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic logic [15:0] regForm(input logic [2:0] rs, input logic [2:0] rt,
                                            input logic [2:0] rd, input logic [1:0] fn);
        return {cpuPkg::OpAlu, rs, rt, rd, fn};
    endfunction

    // Reference model of one instruction, straight from the ISA rules
    function automatic void predictWrite(input logic [15:0] w);
        logic [2:0] rs, rt, dst;
        logic [15:0] a, b, s5, z5, s8, z8, res;
        logic wr;
        rs = w[10:8];
        rt = w[7:5];
        a = modelRegs[rs];
        b = modelRegs[rt];
        s5 = {{11{w[4]}}, w[4:0]};
        z5 = {11'h000, w[4:0]};
        s8 = {{8{w[7]}}, w[7:0]};
        z8 = {8'h00, w[7:0]};
        wr = 1'b1;
        dst = rt;
        res = '0;
        case (w[15:11])
            cpuPkg::OpAddi:  res = a + s5;
            cpuPkg::OpSubi:  res = s5 - a;
            cpuPkg::OpXori:  res = a ^ z5;
            cpuPkg::OpAndni: res = a & ~z5;
            cpuPkg::OpLbi: begin
                dst = rs;
                res = s8;
            end
            cpuPkg::OpSlbi: begin
                dst = rs;
                res = (a << 8) | z8;
            end
            cpuPkg::OpAlu: begin
                dst = w[4:2];
                case (w[1:0])
                    2'b00:   res = a + b;
                    2'b01:   res = b - a;
                    2'b10:   res = a ^ b;
                    default: res = a & ~b;
                endcase
            end
            // Halt, nop and unused opcodes write nothing
            default: wr = 1'b0;
        endcase
        if (wr) begin
            modelRegs[dst] = res;
            expRegQ.push_back(dst);
            expDataQ.push_back(res);
        end
    endfunction

    // Called 2 ns after a rising edge, returns at the same point
    task automatic sendWord(input logic [15:0] word);
        int cycles;
        instrReq = 1'b1;
        instrWord = word;
        cycles = 0;
        while (!instrAck) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > AckTimeout) abortRun("instrAck never rose for a pending request");
        end
        instrReq = 1'b0;
        cycles = 0;
        while (instrAck) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > AckTimeout) abortRun("instrAck stayed high after instrReq fell");
        end
    endtask

    task automatic issueInstr(input logic [15:0] word);
        predictWrite(word);
        sendWord(word);
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (expRegQ.size() != 0) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > DrainTimeout) abortRun("expected register writes never retired");
        end
    endtask

    function automatic logic [15:0] randomInstr();
        logic [31:0] rnd;
        logic [4:0] op;
        int sel;
        rnd = $urandom();
        sel = $urandom_range(9, 0);
        case (sel)
            0:       op = cpuPkg::OpNop;
            1:       op = cpuPkg::OpAddi;
            2:       op = cpuPkg::OpSubi;
            3:       op = cpuPkg::OpXori;
            4:       op = cpuPkg::OpAndni;
            5:       op = cpuPkg::OpLbi;
            6:       op = cpuPkg::OpSlbi;
            7, 8:    op = cpuPkg::OpAlu;
            default: op = 5'b10101;
        endcase
        return {op, rnd[10:0]};
    endfunction

    // Retire checker, sampled mid-cycle
    always @(negedge clk) begin
        logic [2:0] expReg;
        logic [15:0] expData;
        if (!rst && retireEn) begin
            if (expRegQ.size() == 0) begin
                abortRun($sformatf("Retire of r%0d at %0t ns with no write expected",
                                   retireReg, $time));
            end else begin
                expReg = expRegQ.pop_front();
                expData = expDataQ.pop_front();
                checkValue(int'(retireReg), int'(expReg), "retire register");
                checkValue(int'(retireData), int'(expData), "retire data");
            end
        end
    end

    initial begin
        logic [15:0] consts [8];
        int cycles;
        void'($urandom(32'h2613));
        instrReq = 1'b0;
        instrWord = '0;
        consts = '{16'h8001, 16'h7ffe, 16'h1234, 16'hfedc,
                   16'h00ff, 16'hff00, 16'h5a5a, 16'ha5c3};
        for (int i = 0; i < 8; i++) begin
            modelRegs[i] = '0;
        end

        cycles = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > 50) abortRun("reset was never released");
        end

        // Quiet core with no request
        repeat (10) begin
            @(posedge clk);
            #2;
            checkValue(int'(instrAck), 0, "instrAck after reset");
            checkValue(int'(retireEn), 0, "retireEn after reset");
            checkValue(int'(halted), 0, "halted after reset");
        end

        // Full 16-bit constants through Lbi then Slbi
        for (int r = 0; r < 8; r++) begin
            issueInstr(byteForm(cpuPkg::OpLbi, 3'(r), consts[r][15:8]));
            issueInstr(byteForm(cpuPkg::OpSlbi, 3'(r), consts[r][7:0]));
        end
        waitDrain();
        for (int r = 0; r < 8; r++) begin
            checkValue(int'(modelRegs[r]), int'(consts[r]), "constant load");
        end

        // Immediate forms, negative and large immediates
        issueInstr(immForm(cpuPkg::OpAddi, 3'd0, 3'd1, 5'h1f));
        issueInstr(immForm(cpuPkg::OpSubi, 3'd2, 3'd3, 5'h10));
        issueInstr(immForm(cpuPkg::OpXori, 3'd3, 3'd4, 5'h1f));
        issueInstr(immForm(cpuPkg::OpAndni, 3'd4, 3'd6, 5'h1b));
        issueInstr(immForm(cpuPkg::OpAddi, 3'd7, 3'd7, 5'h0f));
        issueInstr(immForm(cpuPkg::OpSubi, 3'd6, 3'd0, 5'h0f));
        waitDrain();
        checkValue(int'(modelRegs[1]), 32'h8000, "addi sign extension");
        checkValue(int'(modelRegs[4]), 32'hEDA3, "xori zero extension");
        checkValue(int'(modelRegs[6]), 32'hEDA0, "andni zero extension");

        // Register form chain, each one reads the previous result
        issueInstr(regForm(3'd2, 3'd3, 3'd1, cpuPkg::FnAdd));
        issueInstr(regForm(3'd1, 3'd4, 3'd2, cpuPkg::FnSub));
        issueInstr(regForm(3'd2, 3'd1, 3'd5, cpuPkg::FnXor));
        issueInstr(regForm(3'd5, 3'd2, 3'd0, cpuPkg::FnAndn));
        issueInstr(regForm(3'd5, 3'd0, 3'd5, cpuPkg::FnAdd));
        waitDrain();

        for (int n = 0; n < RandomCount; n++) begin
            issueInstr(randomInstr());
        end
        waitDrain();

        // Halt, then a request that must stay unanswered
        issueInstr({cpuPkg::OpHalt, 11'h000});
        cycles = 0;
        while (!halted) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > HaltTimeout) abortRun("halted never rose after a halt");
        end
        checkValue(expRegQ.size(), 0, "writes outstanding at halt");
        instrReq = 1'b1;
        instrWord = immForm(cpuPkg::OpAddi, 3'd1, 3'd2, 5'h01);
        repeat (QuietWindow) begin
            @(posedge clk);
            #2;
            checkValue(int'(instrAck), 0, "instrAck after halt");
        end
        instrReq = 1'b0;

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: tb.f
source/cpuPkg.sv
source/instrFetch.sv
source/instrDecoder.sv
source/regFileBypass.sv
source/decodeStage.sv
source/executeStage.sv
source/cpuCore.sv
tb/clockGen.sv
tb/cpuCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and judge the log

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f tb.f --top-module cpuCoreTb -o simv \
    && ./obj_dir/simv > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat "$LOG"
[ -s "$LOG" ] || { echo "Empty simulation log"; exit 1; }
grep -qF '*** TEST FAILED ***' "$LOG" && exit 1 || exit 0
